//--- hw/exu_pkg.sv
package exu_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths and field positions
   ////////////////////////////////////////////////////////////////////////////

   localparam int XLEN       = 32;
   localparam int REG_AW     = 5;

   localparam int ALU_CODE_W = 5;
   localparam int LSU_CODE_W = 4;
   localparam int MDU_CODE_W = 3;

   // register fields inside the instruction word
   localparam int RD_LSB     = 0;
   localparam int RJ_LSB     = 5;
   localparam int RK_LSB     = 10;

   // execution unit of a decoded instruction
   typedef enum logic [1:0] {
      UNIT_ALU = 2'd0,
      UNIT_LSU = 2'd1,
      UNIT_MUL = 2'd2
   } unit_e;

   // multiplier opcodes
   localparam logic [MDU_CODE_W-1:0] MUL_W    = 3'd0;
   localparam logic [MDU_CODE_W-1:0] MULH_W   = 3'd1;
   localparam logic [MDU_CODE_W-1:0] MULH_WU  = 3'd2;
   localparam logic [MDU_CODE_W-1:0] MUL_D    = 3'd3;
   localparam logic [MDU_CODE_W-1:0] MULH_D   = 3'd4;
   localparam logic [MDU_CODE_W-1:0] MULH_DU  = 3'd5;
   localparam logic [MDU_CODE_W-1:0] MULW_D_W = 3'd6;

   ////////////////////////////////////////////////////////////////////////////
   // bundles
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      unit_e                  unit;
      logic                   pc_rel;
      logic                   b_imm;
      logic                   double_read;
      logic                   rd_read;
      logic                   rd2rj;
      logic                   double_word;
      logic [ALU_CODE_W-1:0]  alu_code;
      logic [LSU_CODE_W-1:0]  lsu_code;
      logic [MDU_CODE_W-1:0]  mdu_code;
   } dec_op_t;

   typedef struct packed {
      logic [ALU_CODE_W-1:0]  op;
      logic [XLEN-1:0]        c;
      logic                   double_word;
   } alu_req_t;

   typedef struct packed {
      logic                   valid;
      logic                   signed_op;
      logic                   double_op;
      logic                   hi;
      logic                   short_op;
   } mul_req_t;

   typedef struct packed {
      logic                   valid;
      logic [LSU_CODE_W-1:0]  op;
      logic [REG_AW-1:0]      rd;
      logic                   wen;
   } lsu_req_t;

   // one register file write
   typedef struct packed {
      logic                   wen;
      logic [REG_AW-1:0]      rd;
      logic [XLEN-1:0]        data;
   } wb_t;

endpackage

//--- hw/exu_issue.sv
`timescale 1ns/1ps

module exu_issue
   import exu_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              valid,
   input  dec_op_t           op,
   input  logic              rf_wen,
   input  logic [REG_AW-1:0] rf_target,
   input  logic [XLEN-1:0]   alu_c,

   output alu_req_t          alu,
   output mul_req_t          mul,
   output lsu_req_t          lsu,
   output wb_t               ctl_e,
   output logic              mul_valid_e,
   output logic              lsu_go
);

   ////////////////////////////////////////////////////////////////////////////
   // dispatch at _d
   ////////////////////////////////////////////////////////////////////////////

   logic alu_go;
   logic mul_go;

   assign alu_go = valid && (op.unit == UNIT_ALU);
   assign mul_go = valid && (op.unit == UNIT_MUL);
   assign lsu_go = valid && (op.unit == UNIT_LSU);

   // multiplier flags from the mdu code
   logic mul_signed_d;
   logic mul_double_d;
   logic mul_hi_d;
   logic mul_short_d;

   always_comb begin
      mul_signed_d = (op.mdu_code == MUL_W)  || (op.mdu_code == MULH_W) ||
                     (op.mdu_code == MUL_D)  || (op.mdu_code == MULH_D) ||
                     (op.mdu_code == MULW_D_W);
      mul_double_d = (op.mdu_code == MUL_D)  || (op.mdu_code == MULH_D) ||
                     (op.mdu_code == MULH_DU);
      mul_hi_d     = (op.mdu_code == MULH_W) || (op.mdu_code == MULH_WU) ||
                     (op.mdu_code == MULH_D) || (op.mdu_code == MULH_DU);
      mul_short_d  = (op.mdu_code == MUL_W)  || (op.mdu_code == MULH_W) ||
                     (op.mdu_code == MULH_WU);
   end

   ////////////////////////////////////////////////////////////////////////////
   // d to e registers
   ////////////////////////////////////////////////////////////////////////////

   logic                  alu_wen_e;
   logic                  mul_wen_e;
   logic                  mul_vld_e;
   logic                  lsu_vld_e;

   logic [REG_AW-1:0]     rd_e;
   logic [3:0]            mul_flags_e;
   logic [LSU_CODE_W-1:0] lsu_op_e;
   logic                  lsu_wen_e;

   // valids and write enables
   always_ff @(posedge clk) begin
      if (rst) begin
         alu_wen_e <= 1'b0;
         mul_wen_e <= 1'b0;
         mul_vld_e <= 1'b0;
         lsu_vld_e <= 1'b0;
      end else begin
         alu_wen_e <= rf_wen && alu_go;
         mul_wen_e <= rf_wen && mul_go;
         mul_vld_e <= mul_go;
         lsu_vld_e <= lsu_go;
      end
   end

   // payload, qualified by the valids above
   always_ff @(posedge clk) begin
      alu         <= '{op: op.alu_code, c: alu_c, double_word: op.double_word};
      rd_e        <= rf_target;
      mul_flags_e <= {mul_signed_d, mul_double_d, mul_hi_d, mul_short_d};
      lsu_op_e    <= op.lsu_code;
      lsu_wen_e   <= rf_wen;
   end

   assign mul = '{valid:     mul_vld_e,
                  signed_op: mul_flags_e[3],
                  double_op: mul_flags_e[2],
                  hi:        mul_flags_e[1],
                  short_op:  mul_flags_e[0]};

   assign lsu = '{valid: lsu_vld_e, op: lsu_op_e, rd: rd_e, wen: lsu_wen_e};

   // alu and mul share the fixed-latency rd path
   assign ctl_e = '{wen: alu_wen_e || mul_wen_e, rd: rd_e, data: '0};
   assign mul_valid_e = mul_vld_e;

   // a valid instruction is owned by exactly one unit
   a_one_unit_d: assert property (@(posedge clk) disable iff (rst)
      valid |-> $onehot({alu_go, mul_go, lsu_go}));

endmodule

//--- hw/exu_bypass.sv
`timescale 1ns/1ps

module exu_bypass
   import exu_pkg::*;
#(
   parameter int XLEN = exu_pkg::XLEN
) (
   input  logic              clk,
   input  logic              rst,
   input  logic [31:0]       inst,
   input  logic [XLEN-1:0]   pc,
   input  dec_op_t           op,
   input  logic [XLEN-1:0]   imm,
   input  logic [XLEN-1:0]   rs1_data,
   input  logic [XLEN-1:0]   rs2_data,
   input  wb_t               wb_m,
   input  wb_t               rf_w,

   output logic [REG_AW-1:0] rs1_addr,
   output logic [REG_AW-1:0] rs2_addr,
   output logic [XLEN-1:0]   opa_e,
   output logic [XLEN-1:0]   opb_e,
   output logic [XLEN-1:0]   lsu_offset_e
);

   ////////////////////////////////////////////////////////////////////////////
   // register read and operand select at _d
   ////////////////////////////////////////////////////////////////////////////

   assign rs1_addr = op.rd2rj   ? inst[RD_LSB +: REG_AW] : inst[RJ_LSB +: REG_AW];
   assign rs2_addr = op.rd_read ? inst[RD_LSB +: REG_AW] : inst[RK_LSB +: REG_AW];

   logic [XLEN-1:0] opa_d;
   logic [XLEN-1:0] opb_d;

   assign opa_d = op.pc_rel ? pc  : rs1_data;
   assign opb_d = op.b_imm  ? imm : rs2_data;

   ////////////////////////////////////////////////////////////////////////////
   // d to e registers
   ////////////////////////////////////////////////////////////////////////////

   logic [XLEN-1:0]   src_data_e [2];
   logic [REG_AW-1:0] src_addr_e [2];
   logic [XLEN-1:0]   imm_e;
   logic              pc_rel_e;
   logic              b_imm_e;
   logic              double_read_e;

   always_ff @(posedge clk) begin
      src_data_e[0] <= opa_d;
      src_data_e[1] <= opb_d;
      src_addr_e[0] <= rs1_addr;
      src_addr_e[1] <= rs2_addr;
      imm_e         <= imm;
   end

   // operand source flags
   always_ff @(posedge clk) begin
      if (rst) begin
         pc_rel_e      <= 1'b0;
         b_imm_e       <= 1'b0;
         double_read_e <= 1'b0;
      end else begin
         pc_rel_e      <= op.pc_rel;
         b_imm_e       <= op.b_imm;
         double_read_e <= op.double_read;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // forwarding from _m and _w
   ////////////////////////////////////////////////////////////////////////////

   logic            use_rf_e [2];
   logic [XLEN-1:0] fwd_e    [2];

   // pc and immediate operands never come from a register
   assign use_rf_e[0] = !pc_rel_e;
   assign use_rf_e[1] = !(b_imm_e || double_read_e);

   always_comb begin
      for (int i = 0; i < 2; i++) begin
         if (use_rf_e[i] && wb_m.wen && (wb_m.rd == src_addr_e[i])) begin
            fwd_e[i] = wb_m.data;
         end else if (use_rf_e[i] && rf_w.wen && (rf_w.rd == src_addr_e[i])) begin
            fwd_e[i] = rf_w.data;
         end else begin
            fwd_e[i] = src_data_e[i];
         end
      end
   end

   assign opa_e = fwd_e[0];
   assign opb_e = fwd_e[1];

   // indexed access takes rs2 as the offset
   assign lsu_offset_e = double_read_e ? fwd_e[1] : imm_e;

endmodule

//--- hw/exu_writeback.sv
`timescale 1ns/1ps

module exu_writeback
   import exu_pkg::*;
#(
   parameter int XLEN = exu_pkg::XLEN
) (
   input  logic              clk,
   input  logic              rst,
   input  wb_t               ctl_e,
   input  logic              mul_valid_e,
   input  logic [XLEN-1:0]   alu_res,
   input  logic [XLEN-1:0]   mul_res,
   input  logic [XLEN-1:0]   lsu_rdata,
   input  logic [REG_AW-1:0] lsu_rd,
   input  logic              lsu_wen,
   input  logic              lsu_finish,
   input  logic              lsu_go,

   output wb_t               wb_m,
   output wb_t               rf_w,
   output logic              stall_req
);

   ////////////////////////////////////////////////////////////////////////////
   // e to m
   ////////////////////////////////////////////////////////////////////////////

   logic              wen_m;
   logic              mul_valid_m;
   logic [REG_AW-1:0] rd_m;
   logic [XLEN-1:0]   alu_res_m;

   always_ff @(posedge clk) begin
      if (rst) begin
         wen_m       <= 1'b0;
         mul_valid_m <= 1'b0;
      end else begin
         wen_m       <= ctl_e.wen;
         mul_valid_m <= mul_valid_e;
      end
   end

   always_ff @(posedge clk) begin
      rd_m      <= ctl_e.rd;
      alu_res_m <= alu_res;
   end

   // result merge at _m
   // lsu owns its rd, alu and mul share the pipe rd
   always_comb begin
      if (lsu_finish) begin
         wb_m.wen  = lsu_wen;
         wb_m.rd   = lsu_rd;
         wb_m.data = lsu_rdata;
      end else begin
         wb_m.wen  = wen_m;
         wb_m.rd   = rd_m;
         wb_m.data = mul_valid_m ? mul_res : alu_res_m;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // m to w
   ////////////////////////////////////////////////////////////////////////////

   logic              wen_w;
   logic [REG_AW-1:0] rd_w;
   logic [XLEN-1:0]   data_w;

   always_ff @(posedge clk) begin
      if (rst) begin
         wen_w <= 1'b0;
      end else begin
         wen_w <= wb_m.wen;
      end
   end

   always_ff @(posedge clk) begin
      rd_w   <= wb_m.rd;
      data_w <= wb_m.data;
   end

   assign rf_w = '{wen: wen_w, rd: rd_w, data: data_w};

   ////////////////////////////////////////////////////////////////////////////
   // lsu stall
   ////////////////////////////////////////////////////////////////////////////

   logic lsu_busy;

   // set by the _d dispatch, cleared after the finish cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         lsu_busy <= 1'b0;
      end else begin
         lsu_busy <= lsu_go || (lsu_busy && !lsu_finish);
      end
   end

   // front end holds through the finish cycle
   assign stall_req = lsu_go || lsu_busy;

   // a finish without an access in flight is a unit protocol error
   a_finish_busy: assert property (@(posedge clk) disable iff (rst)
      lsu_finish |-> lsu_busy);

endmodule

//--- hw/exu_ecl.sv
`timescale 1ns/1ps

module exu_ecl
   import exu_pkg::*;
#(
   parameter int XLEN = exu_pkg::XLEN
) (
   input  logic              clk,
   input  logic              rst,

   // decode stage
   input  logic              valid,
   input  logic [31:0]       inst,
   input  logic [XLEN-1:0]   pc,
   input  dec_op_t           op,
   input  logic              rf_wen,
   input  logic [REG_AW-1:0] rf_target,
   input  logic [XLEN-1:0]   imm,
   input  logic [XLEN-1:0]   alu_c,
   input  logic [XLEN-1:0]   rs1_data,
   input  logic [XLEN-1:0]   rs2_data,
   output logic [REG_AW-1:0] rs1_addr,
   output logic [REG_AW-1:0] rs2_addr,

   // alu
   output logic [XLEN-1:0]   alu_a,
   output logic [XLEN-1:0]   alu_b,
   output alu_req_t          alu,
   input  logic [XLEN-1:0]   alu_res,

   // multiplier, result at _m
   output mul_req_t          mul,
   output logic [XLEN-1:0]   mul_a,
   output logic [XLEN-1:0]   mul_b,
   input  logic [XLEN-1:0]   mul_res,

   // load/store
   output lsu_req_t          lsu,
   output logic [XLEN-1:0]   lsu_base,
   output logic [XLEN-1:0]   lsu_offset,
   output logic [XLEN-1:0]   lsu_wdata,
   input  logic [XLEN-1:0]   lsu_rdata,
   input  logic [REG_AW-1:0] lsu_rd,
   input  logic              lsu_wen,
   input  logic              lsu_finish,

   // register file write and front end hold
   output wb_t               rf_w,
   output logic              stall_req
);

   wb_t             ctl_e;
   wb_t             wb_m;
   logic            mul_valid_e;
   logic            lsu_go;
   logic [XLEN-1:0] opa_e;
   logic [XLEN-1:0] opb_e;
   logic [XLEN-1:0] lsu_offset_e;

   exu_issue i_issue (
      .clk         (clk),
      .rst         (rst),
      .valid       (valid),
      .op          (op),
      .rf_wen      (rf_wen),
      .rf_target   (rf_target),
      .alu_c       (alu_c),
      .alu         (alu),
      .mul         (mul),
      .lsu         (lsu),
      .ctl_e       (ctl_e),
      .mul_valid_e (mul_valid_e),
      .lsu_go      (lsu_go)
   );

   exu_bypass #(.XLEN(XLEN)) i_bypass (
      .clk          (clk),
      .rst          (rst),
      .inst         (inst),
      .pc           (pc),
      .op           (op),
      .imm          (imm),
      .rs1_data     (rs1_data),
      .rs2_data     (rs2_data),
      .wb_m         (wb_m),
      .rf_w         (rf_w),
      .rs1_addr     (rs1_addr),
      .rs2_addr     (rs2_addr),
      .opa_e        (opa_e),
      .opb_e        (opb_e),
      .lsu_offset_e (lsu_offset_e)
   );

   exu_writeback #(.XLEN(XLEN)) i_writeback (
      .clk         (clk),
      .rst         (rst),
      .ctl_e       (ctl_e),
      .mul_valid_e (mul_valid_e),
      .alu_res     (alu_res),
      .mul_res     (mul_res),
      .lsu_rdata   (lsu_rdata),
      .lsu_rd      (lsu_rd),
      .lsu_wen     (lsu_wen),
      .lsu_finish  (lsu_finish),
      .lsu_go      (lsu_go),
      .wb_m        (wb_m),
      .rf_w        (rf_w),
      .stall_req   (stall_req)
   );

   // forwarded operands fan out to all three units
   assign alu_a      = opa_e;
   assign alu_b      = opb_e;
   assign mul_a      = opa_e;
   assign mul_b      = opb_e;
   assign lsu_base   = opa_e;
   assign lsu_wdata  = opb_e;
   assign lsu_offset = lsu_offset_e;

endmodule

//--- sim/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// architectural register file, updated in program order
logic [31:0] arch_rf [32];

// fill pattern per register index
function automatic logic [31:0] fill_value(input int idx);
   return 32'hA5A5_0000 ^ (32'(idx) * 32'h0101_0101);
endfunction

// rd at [4:0], rj at [9:5], rk at [14:10]
function automatic logic [4:0] ref_rs1(input logic [31:0] i, input dec_op_t o);
   return o.rd2rj ? i[4:0] : i[9:5];
endfunction

function automatic logic [4:0] ref_rs2(input logic [31:0] i, input dec_op_t o);
   return o.rd_read ? i[4:0] : i[14:10];
endfunction

function automatic logic [31:0] ref_opa(input logic [31:0] p, input dec_op_t o,
                                        input logic [31:0] i);
   return o.pc_rel ? p : arch_rf[ref_rs1(i, o)];
endfunction

function automatic logic [31:0] ref_opb(input logic [31:0] im, input dec_op_t o,
                                        input logic [31:0] i);
   return o.b_imm ? im : arch_rf[ref_rs2(i, o)];
endfunction

`endif

//--- sim/tb_exu_ecl.sv
`timescale 1ns/1ps

module tb_exu_ecl
   import exu_pkg::*;
;

   localparam int N_INST  = 3000;
   localparam int MAX_CYC = N_INST * 6;

   logic              clk;
   logic              rst;
   logic              valid;
   logic [31:0]       inst;
   logic [31:0]       pc;
   dec_op_t           op;
   logic              rf_wen;
   logic [REG_AW-1:0] rf_target;
   logic [31:0]       imm;
   logic [31:0]       alu_c;
   logic [31:0]       rs1_data;
   logic [31:0]       rs2_data;
   logic [REG_AW-1:0] rs1_addr;
   logic [REG_AW-1:0] rs2_addr;
   logic [31:0]       alu_a;
   logic [31:0]       alu_b;
   alu_req_t          alu;
   logic [31:0]       alu_res;
   mul_req_t          mul;
   logic [31:0]       mul_a;
   logic [31:0]       mul_b;
   logic [31:0]       mul_res;
   lsu_req_t          lsu;
   logic [31:0]       lsu_base;
   logic [31:0]       lsu_offset;
   logic [31:0]       lsu_wdata;
   logic [31:0]       lsu_rdata;
   logic [REG_AW-1:0] lsu_rd;
   logic              lsu_wen;
   logic              lsu_finish;
   wb_t               rf_w;
   logic              stall_req;

   `include "tb_ref_model.svh"

   // expected state of one instruction at _e
   typedef struct packed {
      logic              vld;
      dec_op_t           op;
      logic              wen;
      logic [REG_AW-1:0] rd;
      logic [31:0]       a;
      logic [31:0]       b;
      logic [31:0]       c;
      logic [31:0]       off;
   } exec_t;

   // expected rf_w write and the cycle it shows up
   typedef struct packed {
      logic [31:0]       due;
      logic              wen;
      logic [REG_AW-1:0] rd;
      logic [31:0]       data;
   } wr_t;

   logic [31:0]       rf_mem [32];
   exec_t             exp_d;
   exec_t             exp_e;
   wr_t               wr_q [$];
   int                cyc;
   int                issued;
   int                last_issue;
   logic              lsu_waiting;
   logic [REG_AW-1:0] pend_rd;
   logic              pend_wen;
   int                lsu_cnt;
   logic [REG_AW-1:0] seen_rd;
   logic              seen_wen;
   logic [31:0]       mul_next;

   exu_ecl #(.XLEN(32)) i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // unit and register file models
   ////////////////////////////////////////////////////////////////////////////

   // write-first register file
   assign rs1_data = (rf_w.wen && rf_w.rd == rs1_addr) ? rf_w.data : rf_mem[rs1_addr];
   assign rs2_data = (rf_w.wen && rf_w.rd == rs2_addr) ? rf_w.data : rf_mem[rs2_addr];

   always @(posedge clk) begin
      if (rf_w.wen) begin
         rf_mem[rf_w.rd] <= rf_w.data;
      end
   end

   assign alu_res = alu_a + alu_b;

   function automatic logic [3:0] mul_flags(input logic [MDU_CODE_W-1:0] code);
      // signed, double, hi, short
      case (code)
         MUL_W:    return 4'b1001;
         MULH_W:   return 4'b1011;
         MULH_WU:  return 4'b0011;
         MUL_D:    return 4'b1100;
         MULH_D:   return 4'b1110;
         MULH_DU:  return 4'b0110;
         MULW_D_W: return 4'b1000;
         default:  return 4'b0000;
      endcase
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         $display("Test failed");
         $fatal(1, "value mismatch in %s", name);
      end
   endtask

   // finish pulse and load data
   task automatic drive_lsu();
      wr_t w;
      lsu_finish = 1'b0;
      if (lsu_cnt > 0) begin
         lsu_cnt--;
         if (lsu_cnt == 0) begin
            lsu_finish = 1'b1;
            lsu_rdata  = $urandom;
            lsu_rd     = seen_rd;
            lsu_wen    = seen_wen;
            w = '{due: 32'(cyc + 1), wen: pend_wen, rd: pend_rd, data: lsu_rdata};
            wr_q.push_back(w);
            if (pend_wen) begin
               arch_rf[pend_rd] = lsu_rdata;
            end
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////////////////////

   task automatic drive_slot();
      dec_op_t     o;
      int          pick;
      logic        go;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      exec_t       x;
      wr_t         w;
      o         = '0;
      pick      = int'($urandom_range(0, 99));
      // small register range so that dependencies are frequent
      inst      = {17'($urandom), 2'b00, 3'($urandom_range(0, 7)),
                   2'b00, 3'($urandom_range(0, 7)), 2'b00, 3'($urandom_range(0, 7))};
      pc        = $urandom & 32'hFFFF_FFFC;
      imm       = $urandom;
      alu_c     = $urandom;
      rf_target = 5'($urandom_range(0, 7));
      rf_wen    = ($urandom_range(0, 9) != 0);
      o.rd2rj       = ($urandom_range(0, 4) == 0);
      o.rd_read     = ($urandom_range(0, 4) == 0);
      o.alu_code    = 5'($urandom);
      o.lsu_code    = 4'($urandom);
      o.mdu_code    = 3'($urandom_range(0, 6));
      o.double_word = 1'($urandom);
      if (pick < 55) begin
         o.unit   = UNIT_ALU;
         o.pc_rel = ($urandom_range(0, 3) == 0);
         o.b_imm  = ($urandom_range(0, 9) < 3);
      end else if (pick < 85) begin
         o.unit = UNIT_MUL;
      end else begin
         o.unit        = UNIT_LSU;
         o.double_read = 1'($urandom);
         o.b_imm       = !o.double_read;
      end
      go = (issued < N_INST) && !lsu_waiting && ($urandom_range(0, 9) != 0);
      // loads and stores wait until older writes have reached the register file
      if (o.unit == UNIT_LSU && (cyc - last_issue) < 3) begin
         go = 1'b0;
      end
      op    = o;
      valid = go;
      if (go) begin
         a   = ref_opa(pc, o, inst);
         b   = ref_opb(imm, o, inst);
         res = (o.unit == UNIT_MUL) ? a * b : a + b;
         x   = '{vld: 1'b1, op: o, wen: rf_wen, rd: rf_target, a: a, b: b, c: alu_c,
                 off: o.double_read ? b : imm};
         if (o.unit == UNIT_LSU) begin
            lsu_waiting = 1'b1;
            pend_rd     = rf_target;
            pend_wen    = rf_wen;
         end else begin
            w = '{due: 32'(cyc + 3), wen: rf_wen, rd: rf_target, data: res};
            wr_q.push_back(w);
            if (rf_wen) begin
               arch_rf[rf_target] = res;
            end
         end
         exp_d      = x;
         issued++;
         last_issue = cyc;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // checks at the falling edge
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_cycle();
      wr_t w;
      check("rs1_addr", 32'(ref_rs1(inst, op)), 32'(rs1_addr));
      check("rs2_addr", 32'(ref_rs2(inst, op)), 32'(rs2_addr));
      check("stall_req", 32'((valid && op.unit == UNIT_LSU) || lsu_waiting), 32'(stall_req));
      if (lsu_finish) begin
         lsu_waiting = 1'b0;
      end
      check("mul_valid", 32'(exp_e.vld && exp_e.op.unit == UNIT_MUL), 32'(mul.valid));
      check("lsu_valid", 32'(exp_e.vld && exp_e.op.unit == UNIT_LSU), 32'(lsu.valid));
      if (exp_e.vld && exp_e.op.unit == UNIT_ALU) begin
         check("alu_a", exp_e.a, alu_a);
         check("alu_b", exp_e.b, alu_b);
         check("alu_c", exp_e.c, alu.c);
         check("alu_op", 32'(exp_e.op.alu_code), 32'(alu.op));
         check("alu_dw", 32'(exp_e.op.double_word), 32'(alu.double_word));
      end
      if (exp_e.vld && exp_e.op.unit == UNIT_MUL) begin
         check("mul_a", exp_e.a, mul_a);
         check("mul_b", exp_e.b, mul_b);
         check("mul_flags", 32'(mul_flags(exp_e.op.mdu_code)),
               32'({mul.signed_op, mul.double_op, mul.hi, mul.short_op}));
      end
      if (exp_e.vld && exp_e.op.unit == UNIT_LSU) begin
         check("lsu_op", 32'(exp_e.op.lsu_code), 32'(lsu.op));
         check("lsu_rd", 32'(exp_e.rd), 32'(lsu.rd));
         check("lsu_wen", 32'(exp_e.wen), 32'(lsu.wen));
         check("lsu_base", exp_e.a, lsu_base);
         check("lsu_offset", exp_e.off, lsu_offset);
         check("lsu_wdata", exp_e.b, lsu_wdata);
      end
      // lsu model picks up the request
      if (lsu.valid) begin
         lsu_cnt  = int'($urandom_range(1, 4));
         seen_rd  = lsu.rd;
         seen_wen = lsu.wen;
      end
      mul_next = mul_a * mul_b;
      if (wr_q.size() > 0 && wr_q[0].due == 32'(cyc)) begin
         w = wr_q.pop_front();
         check("rf_w_wen", 32'(w.wen), 32'(rf_w.wen));
         if (w.wen) begin
            check("rf_w_rd", 32'(w.rd), 32'(rf_w.rd));
            check("rf_w_data", w.data, rf_w.data);
         end
      end else begin
         check("rf_w_wen", 32'(0), 32'(rf_w.wen));
      end
   endtask

   task automatic step();
      @(posedge clk);
      cyc++;
      #1;
      mul_res = mul_next;
      drive_lsu();
      exp_e = exp_d;
      exp_d = '0;
      drive_slot();
      @(negedge clk);
      check_cycle();
   endtask

   initial begin
      void'($urandom(32'h9448));
      rst         = 1'b1;
      valid       = 1'b0;
      inst        = '0;
      pc          = '0;
      op          = '0;
      rf_wen      = 1'b0;
      rf_target   = '0;
      imm         = '0;
      alu_c       = '0;
      mul_res     = '0;
      lsu_rdata   = '0;
      lsu_rd      = '0;
      lsu_wen     = 1'b0;
      lsu_finish  = 1'b0;
      exp_d       = '0;
      exp_e       = '0;
      cyc         = 0;
      issued      = 0;
      last_issue  = -10;
      lsu_waiting = 1'b0;
      lsu_cnt     = 0;
      mul_next    = '0;
      for (int i = 0; i < 32; i++) begin
         rf_mem[i]  = fill_value(i);
         arch_rf[i] = fill_value(i);
      end
      repeat (16) @(posedge clk);
      #1 rst = 1'b0;
      while (issued < N_INST) begin
         step();
      end
      // drain the pipe and any load still in flight
      repeat (12) step();
      if (wr_q.size() != 0 || lsu_waiting) begin
         $display("register writes still outstanding at the end of the run");
         $display("Test failed");
         $fatal(1, "pipeline did not drain");
      end else begin
         $display("Test passed");
         $finish;
      end
   end

   // watchdog
   initial begin
      repeat (MAX_CYC + 16) @(posedge clk);
      $display("watchdog expired before all instructions completed");
      $display("Test failed");
      $fatal(1, "timeout");
   end

endmodule

//--- files.f
+incdir+sim
hw/exu_pkg.sv
hw/exu_issue.sv
hw/exu_bypass.sv
hw/exu_writeback.sv
hw/exu_ecl.sv
sim/tb_exu_ecl.sv

//--- run.sh
#!/bin/sh
# build and run the execute-stage testbench with Verilator

verilator --binary --timing --assert \
   -f files.f \
   --top-module tb_exu_ecl \
   -Mdir obj_dir \
   && ./obj_dir/Vtb_exu_ecl \
   || exit 1
